//--- hdl/align_buffer.sv
/*
  Instruction alignment buffer top level
  Fetch control, response FIFO and output extraction on plain ports
*/

`timescale 1ns/1ns

module align_buffer import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  kill_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  prefetch_en_i,
  output logic  prefetch_busy_o,
  // Request side
  output logic  fetch_valid_o,
  input  logic  fetch_ready_i,
  output logic  fetch_branch_o,
  output addr_t fetch_branch_addr_o,
  // Response side, no ready
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  // Issue side
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o
);

  logic resp_valid_gated;
  logic issue;

  resp_view_if view ();

  // Fetches are word aligned
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[ADDR_W-1:2], 2'b00};

  fetch_ctrl u_fetch_ctrl (
    .clk, .rst_n, .kill_i, .branch_i, .branch_addr_i, .prefetch_en_i,
    .fetch_ready_i, .resp_valid_i, .resp_rdata_i,
    .issue_i            (issue),
    .fetch_valid_o, .prefetch_busy_o,
    .resp_valid_gated_o (resp_valid_gated)
  );

  resp_fifo u_resp_fifo (
    .clk, .rst_n, .kill_i,
    .resp_valid_gated_i (resp_valid_gated),
    .resp_rdata_i, .resp_err_i,
    .view               (view.fifo)
  );

  instr_aligner u_instr_aligner (
    .clk, .rst_n, .kill_i, .branch_i, .branch_addr_i,
    .resp_valid_gated_i (resp_valid_gated),
    .resp_rdata_i, .resp_err_i, .instr_ready_i,
    .view               (view.aligner),
    .issue_o            (issue),
    .instr_valid_o, .instr_rdata_o, .instr_err_o, .instr_addr_o
  );

endmodule

//--- hdl/align_pkg.sv
/*
  Shared widths, depth and limits of the instruction alignment buffer
  Vector types for addresses, fetched words, halfwords and counters
*/

package align_pkg;

  // Address and data widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int HALF_W = WORD_W / 2;

  // Three entries is the minimum that keeps the buffer from stalling
  localparam int FIFO_DEPTH = 3;

  // Fetch requests in flight
  localparam int MAX_OUTSTANDING = 2;

  // Low two bits of an uncompressed (32-bit) instruction
  localparam logic [1:0] RVC_OPCODE_FULL = 2'b11;

  // Counters hold up to two instructions per entry, so 0 to FIFO_DEPTH fits too
  localparam int CNT_W = $clog2(2 * FIFO_DEPTH + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [HALF_W-1:0] half_t;
  typedef logic [CNT_W-1:0]  cnt_t;

endpackage

//--- hdl/fetch_ctrl.sv
/*
  Fetch side control of the alignment buffer
  Request rule, outstanding/instruction/flush counters, alignment tracker
  The controller is expected to raise kill_i together with every branch
*/

`timescale 1ns/1ns

module fetch_ctrl import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  kill_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  prefetch_en_i,
  input  logic  fetch_ready_i,
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  issue_i,
  output logic  fetch_valid_o,
  output logic  prefetch_busy_o,
  output logic  resp_valid_gated_o
);

  cnt_t       outstanding_cnt_q, outstanding_cnt_n;
  cnt_t       instr_cnt_q, instr_cnt_n;
  cnt_t       flush_cnt_q, flush_cnt_n;
  logic       aligned_q, aligned_n;
  logic       complete_q, complete_n;
  logic [1:0] n_incoming;
  logic [1:0] n_lower;
  logic       req_accept;

  ////////////////////////////////
  // Request rule
  ////////////////////////////////

  // Ask for a word when the buffer runs dry, or on a branch
  assign fetch_valid_o = prefetch_en_i && (outstanding_cnt_q < cnt_t'(MAX_OUTSTANDING)) &&
                         ((instr_cnt_q == '0) ||
                          (instr_cnt_q == cnt_t'(1) && outstanding_cnt_q == '0) ||
                          branch_i);

  assign prefetch_busy_o = (outstanding_cnt_q != '0) || fetch_valid_o;
  assign req_accept      = fetch_valid_o && fetch_ready_i;

  // Responses of the old stream never reach the FIFO
  // A response in the branch cycle itself belongs to the old stream
  assign resp_valid_gated_o = resp_valid_i && (flush_cnt_q == '0) && !branch_i;

  ////////////////////////////////
  // Counters
  ////////////////////////////////

  always_comb begin
    outstanding_cnt_n = outstanding_cnt_q;
    if (req_accept && !resp_valid_i) begin
      outstanding_cnt_n = outstanding_cnt_q + cnt_t'(1);
    end else if (!req_accept && resp_valid_i) begin
      outstanding_cnt_n = outstanding_cnt_q - cnt_t'(1);
    end
  end

  // Flush whatever is still in flight at a branch
  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_n = resp_valid_i ? outstanding_cnt_q - cnt_t'(1) : outstanding_cnt_q;
    end else if (resp_valid_i && flush_cnt_q != '0) begin
      flush_cnt_n = flush_cnt_q - cnt_t'(1);
    end
  end

  // Whole instructions held, incoming ones counted in their arrival cycle
  always_comb begin
    if (kill_i || branch_i) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + cnt_t'(n_incoming) - cnt_t'(issue_i);
    end
  end

  ////////////////////////////////
  // Alignment tracker
  ////////////////////////////////

  // aligned=0 with complete=1 only follows an unaligned branch
  // and means the lower half of the next word is skipped
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    // Lower half completes one unless it is skipped
    n_lower    = (aligned_q || !complete_q) ? 2'd1 : 2'd0;
    if (branch_i) begin
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_valid_gated_o) begin
      if (aligned_q && resp_rdata_i[1:0] == RVC_OPCODE_FULL) begin
        // Whole word is one instruction, alignment kept
        n_incoming = 2'd1;
      end else if (resp_rdata_i[17:16] == RVC_OPCODE_FULL) begin
        // Upper half starts a split instruction
        n_incoming = n_lower;
        aligned_n  = 1'b0;
        complete_n = 1'b0;
      end else begin
        // Compressed in the upper half
        n_incoming = n_lower + 2'd1;
        aligned_n  = 1'b1;
        complete_n = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_cnt_q <= '0;
      instr_cnt_q       <= '0;
      flush_cnt_q       <= '0;
      aligned_q         <= 1'b0;
      complete_q        <= 1'b0;
    end else begin
      outstanding_cnt_q <= outstanding_cnt_n;
      instr_cnt_q       <= instr_cnt_n;
      flush_cnt_q       <= flush_cnt_n;
      aligned_q         <= aligned_n;
      complete_q        <= complete_n;
    end
  end

endmodule

//--- hdl/instr_aligner.sv
/*
  Output extraction of the alignment buffer
  Instruction address register, aligned/split multiplexing, error merge
*/

`timescale 1ns/1ns

module instr_aligner import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  kill_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  resp_valid_gated_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  input  logic  instr_ready_i,
  resp_view_if.aligner view,
  output logic  issue_o,
  output logic  instr_valid_o,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o
);

  addr_t addr_q, addr_n, addr_incr;
  word_t first_word;
  half_t second_lo;
  logic  first_err, second_err;
  logic  avail, avail_split;
  logic  aligned_compressed, unaligned_compressed;

  // First word is entry 0, or the incoming word when the FIFO is empty
  assign first_word = view.head_valid ? view.head_data : resp_rdata_i;
  assign first_err  = view.head_valid ? view.head_err : resp_err_i;

  // Second half of a split instruction is entry 1 or the incoming word
  assign second_lo  = view.next_valid ? view.next_data[HALF_W-1:0] : resp_rdata_i[HALF_W-1:0];
  assign second_err = view.next_valid ? view.next_err : resp_err_i;

  // Compressed flags are only meaningful while a word is available
  assign aligned_compressed   = first_word[1:0] != RVC_OPCODE_FULL;
  assign unaligned_compressed = first_word[17:16] != RVC_OPCODE_FULL;

  assign avail       = view.head_valid || resp_valid_gated_i;
  assign avail_split = view.next_valid || (view.head_valid && resp_valid_gated_i);

  // Output mux, combinational in the current cycle
  always_comb begin
    instr_rdata_o = first_word;
    instr_err_o   = first_err;
    instr_valid_o = avail;
    if (addr_q[1]) begin
      instr_rdata_o = {second_lo, first_word[WORD_W-1:HALF_W]};
      // Both words count when the instruction straddles them
      instr_err_o   = unaligned_compressed ? first_err : (first_err || second_err);
      instr_valid_o = unaligned_compressed ? avail : avail_split;
    end
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end
  end

  assign issue_o = instr_valid_o && instr_ready_i;

  // Split instructions always consume entry 0, aligned ones only if full width
  assign view.advance = issue_o && (addr_q[1] || !aligned_compressed);

  ////////////////////////////////
  // Address update
  ////////////////////////////////

  assign addr_incr = {addr_q[ADDR_W-1:2], 2'b00} + addr_t'(4);

  always_comb begin
    addr_n = addr_q;
    if (branch_i) begin
      addr_n = branch_addr_i;
    end else if (issue_o) begin
      if (addr_q[1]) begin
        addr_n = unaligned_compressed ? addr_incr : {addr_incr[ADDR_W-1:2], 2'b10};
      end else begin
        addr_n = aligned_compressed ? {addr_q[ADDR_W-1:2], 2'b10} : addr_incr;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

//--- hdl/resp_fifo.sv
/*
  Three-entry storage for fetched response words
  Push to first free entry, shift on advance, clear on kill
*/

`timescale 1ns/1ns

module resp_fifo import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  kill_i,
  input  logic  resp_valid_gated_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  resp_view_if.fifo view
);

  // Entry 0 is the oldest word
  word_t                 data_q [0:FIFO_DEPTH-1];
  word_t                 data_int [0:FIFO_DEPTH-1];
  word_t                 data_n [0:FIFO_DEPTH-1];
  logic [0:FIFO_DEPTH-1] err_q, err_int, err_n;
  logic [0:FIFO_DEPTH-1] valid_q, valid_int, valid_n;
  logic                  placed;

  // Write the incoming word to the first free entry
  always_comb begin
    data_int  = data_q;
    err_int   = err_q;
    valid_int = valid_q;
    placed    = 1'b0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      if (resp_valid_gated_i && !valid_q[i] && !placed) begin
        data_int[i]  = resp_rdata_i;
        err_int[i]   = resp_err_i;
        valid_int[i] = 1'b1;
        placed       = 1'b1;
      end
    end
  end

  // Drop entry 0, a word pushed this cycle included
  always_comb begin
    data_n  = data_int;
    err_n   = err_int;
    valid_n = valid_int;
    if (view.advance) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        data_n[i] = data_int[i+1];
      end
      err_n   = {err_int[1:FIFO_DEPTH-1], 1'b0};
      valid_n = {valid_int[1:FIFO_DEPTH-1], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (kill_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= data_n;
    err_q  <= err_n;
  end

  assign view.head_data  = data_q[0];
  assign view.head_err   = err_q[0];
  assign view.head_valid = valid_q[0];
  assign view.next_data  = data_q[1];
  assign view.next_err   = err_q[1];
  assign view.next_valid = valid_q[1];

endmodule

//--- hdl/resp_view_if.sv
/*
  View of the response FIFO head between storage and extraction
  Entry 0 and entry 1 contents with valid flags, plus the advance strobe
*/

`timescale 1ns/1ns

interface resp_view_if import align_pkg::*; ();

  // Entry 0, the oldest buffered word
  word_t head_data;
  logic  head_err;
  logic  head_valid;

  // Entry 1, second half source for split instructions
  word_t next_data;
  logic  next_err;
  logic  next_valid;

  // Discard entry 0 and shift the rest this cycle
  logic  advance;

  modport fifo (
    output head_data, head_err, head_valid,
    output next_data, next_err, next_valid,
    input  advance
  );

  modport aligner (
    input  head_data, head_err, head_valid,
    input  next_data, next_err, next_valid,
    output advance
  );

endinterface

//--- sim.f
hdl/align_pkg.sv
hdl/resp_view_if.sv
hdl/fetch_ctrl.sv
hdl/resp_fifo.sv
hdl/instr_aligner.sv
hdl/align_buffer.sv
tests/align_buffer_chk.sv
tests/tb_align_buffer.sv

//--- tests/align_buffer_chk.sv
/*
  Assertions bound to the alignment buffer top level
  Request limit, kill masking, stable outputs under back-pressure
*/

`timescale 1ns/1ns

module align_buffer_chk import align_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  kill_i,
  input  logic  fetch_valid_i,
  input  logic  fetch_ready_i,
  input  logic  resp_valid_i,
  input  logic  instr_valid_i,
  input  logic  instr_ready_i,
  input  word_t instr_rdata_i,
  input  logic  instr_err_i,
  input  addr_t instr_addr_i
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;
  cnt_t        in_flight_q;

  // Own count of requests in flight, one per raw response retired
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + cnt_t'(fetch_valid_i && fetch_ready_i) - cnt_t'(resp_valid_i);
    end
  end

  a_req_limit: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight_q == cnt_t'(MAX_OUTSTANDING) |-> !fetch_valid_i)
  else begin
    fail_cnt++;
    $error("fetch request raised with two requests in flight");
  end

  a_kill_masks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !instr_valid_i)
  else begin
    fail_cnt++;
    $error("instruction valid while kill is high");
  end

  // Upper half of a compressed instruction is don't care
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i && !instr_ready_i && !kill_i |=> kill_i ||
    (instr_valid_i && $stable(instr_addr_i) && $stable(instr_err_i) &&
     $stable(instr_rdata_i[15:0])))
  else begin
    fail_cnt++;
    $error("instruction changed while stalled");
  end

  a_hold_full: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i && !instr_ready_i && !kill_i && instr_rdata_i[1:0] == RVC_OPCODE_FULL
    |=> kill_i || $stable(instr_rdata_i))
  else begin
    fail_cnt++;
    $error("uncompressed instruction changed while stalled");
  end

endmodule

//--- tests/tb_align_buffer.sv
/*
  Testbench for the instruction alignment buffer
  Clock, reset, fetch memory model with latency, directed tests
  Per-instruction comparison against a walk of the memory image
*/

`timescale 1ns/1ns

module tb_align_buffer import align_pkg::*; ();

  // About four times the length of all tests together
  localparam int TIMEOUT_CYCLES = 2000;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  kill_i, branch_i, prefetch_en_i, fetch_ready_i, instr_ready_i;
  addr_t branch_addr_i;
  logic  resp_valid_i = 1'b0;
  logic  resp_err_i = 1'b0;
  word_t resp_rdata_i = '0;
  logic  prefetch_busy_o, fetch_valid_o, fetch_branch_o;
  logic  instr_valid_o, instr_err_o;
  addr_t fetch_branch_addr_o, instr_addr_o;
  word_t instr_rdata_o;

  // Instruction image, wraps every 256 bytes
  word_t mem [0:63];
  logic  err_mem [0:63];

  // Requests in flight, oldest first
  addr_t req_addr_q [$];
  int    req_due_q [$];
  addr_t next_addr;
  int    latency = 1;
  int    cyc;
  int    in_flight;
  int    timeout_cnt = 0;

  align_buffer u_align_buffer (.*);

  bind align_buffer align_buffer_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (kill_i),
    .fetch_valid_i (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_i (instr_rdata_o),
    .instr_err_i   (instr_err_o),
    .instr_addr_i  (instr_addr_o)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Fetch memory model
  //////////////////////////////

  // In-order responses, each one latency cycles after its request
  always @(posedge clk) begin
    addr_t a;
    if (!rst_n) begin
      req_addr_q.delete();
      req_due_q.delete();
      resp_valid_i <= 1'b0;
      next_addr = '0;
      in_flight = 0;
      cyc       = 0;
    end else begin
      in_flight = in_flight + int'(fetch_valid_o && fetch_ready_i) - int'(resp_valid_i);
      // A redirect that is not accepted at once is fetched next
      a = fetch_branch_o ? fetch_branch_addr_o : next_addr;
      if (fetch_valid_o && fetch_ready_i) begin
        req_addr_q.push_back(a);
        req_due_q.push_back(cyc + latency);
        next_addr = a + addr_t'(4);
      end else if (fetch_branch_o) begin
        next_addr = a;
      end
      resp_valid_i <= 1'b0;
      if (req_due_q.size() != 0 && req_due_q[0] <= cyc + 1) begin
        a = req_addr_q.pop_front();
        void'(req_due_q.pop_front());
        resp_valid_i <= 1'b1;
        resp_rdata_i <= mem[a[7:2]];
        resp_err_i   <= err_mem[a[7:2]];
      end
      cyc++;
    end
  end

  always @(posedge clk) begin
    timeout_cnt++;
    if (timeout_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic half_t half_at(input addr_t a);
    word_t w;
    w = mem[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic check_value(input string test, input string what,
                             input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error %s: %s expected %h actual %h", test, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "%s: %s mismatch", test, what);
    end
  endtask

  // Fresh random image, no bus errors
  task automatic fill_image();
    for (int i = 0; i < 64; i++) begin
      mem[i]     = $urandom();
      err_mem[i] = 1'b0;
    end
  endtask

  // Redirect, with kill raised together with the branch
  task automatic branch_to(input addr_t target);
    @(posedge clk);
    branch_i      <= 1'b1;
    kill_i        <= 1'b1;
    branch_addr_i <= target;
    prefetch_en_i <= 1'b1;
    instr_ready_i <= 1'b0;
    @(posedge clk);
    branch_i <= 1'b0;
    kill_i   <= 1'b0;
  endtask

  // Accept count instructions, compare each with the walk from pc
  task automatic collect(input string test, inout addr_t pc,
                         input int count, input int stall_pct);
    addr_t pc2;
    half_t lo;
    word_t exp_data, mask;
    logic  exp_err;
    int    size;
    int    got;
    got = 0;
    while (got < count) begin
      instr_ready_i <= ($urandom_range(99) >= stall_pct);
      @(posedge clk);
      if (instr_valid_o && instr_ready_i) begin
        pc2     = pc + addr_t'(2);
        lo      = half_at(pc);
        exp_err = err_mem[pc[7:2]];
        // Full width takes the next halfword, and its word's error
        if (lo[1:0] == RVC_OPCODE_FULL) begin
          exp_data = {half_at(pc2), lo};
          exp_err  = exp_err | err_mem[pc2[7:2]];
          mask     = '1;
          size     = 4;
        end else begin
          exp_data = word_t'(lo);
          mask     = word_t'(16'hffff);
          size     = 2;
        end
        check_value(test, "address", pc, instr_addr_o);
        check_value(test, "data", exp_data, instr_rdata_o & mask);
        check_value(test, "error", word_t'(exp_err), word_t'(instr_err_o));
        pc = pc + addr_t'(size);
        got++;
      end
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic aligned_stream();
    addr_t pc;
    latency = 1;
    fill_image();
    for (int i = 0; i < 64; i++) begin
      mem[i][1:0] = RVC_OPCODE_FULL;
    end
    pc = 32'h40;
    branch_to(pc);
    collect("aligned_stream", pc, 16, 0);
  endtask

  task automatic mixed_stream();
    addr_t pc;
    latency = 2;
    fill_image();
    pc = 32'h20;
    branch_to(pc);
    collect("mixed_stream", pc, 24, 20);
  endtask

  // Upper half of word 5 first compressed, then starting a split
  task automatic unaligned_branch();
    addr_t pc;
    latency = 1;
    fill_image();
    mem[5][17:16] = 2'b01;
    pc = 32'h16;
    branch_to(pc);
    collect("unaligned_branch", pc, 6, 0);
    mem[5][17:16] = RVC_OPCODE_FULL;
    pc = 32'h16;
    branch_to(pc);
    collect("unaligned_branch", pc, 6, 0);
  endtask

  task automatic branch_flush();
    addr_t pc;
    latency = 3;
    fill_image();
    for (int i = 0; i < 32; i++) begin
      mem[i][1:0] = RVC_OPCODE_FULL;
    end
    pc = 32'h00;
    branch_to(pc);
    collect("branch_flush", pc, 4, 0);
    // Next cycle keeps two in flight when no response is due now
    do begin
      @(negedge clk);
    end while (!(in_flight == MAX_OUTSTANDING && !resp_valid_i));
    pc = 32'h80;
    branch_to(pc);
    collect("branch_flush", pc, 12, 0);
  endtask

  // Five compressed, then a split over words 2 and 3 with word 3 in error
  task automatic error_merge();
    addr_t pc;
    latency = 1;
    fill_image();
    for (int i = 0; i < 2; i++) begin
      mem[i][1:0]   = 2'b01;
      mem[i][17:16] = 2'b10;
    end
    mem[2][1:0]   = 2'b00;
    mem[2][17:16] = RVC_OPCODE_FULL;
    err_mem[3]    = 1'b1;
    pc = 32'h00;
    branch_to(pc);
    collect("error_merge", pc, 12, 0);
  endtask

  task automatic backpressure_kill();
    addr_t pc;
    latency = 2;
    fill_image();
    pc = 32'h40;
    branch_to(pc);
    collect("backpressure_kill", pc, 16, 60);
    // Hold off issue until the buffer stops fetching
    instr_ready_i <= 1'b0;
    do begin
      @(negedge clk);
    end while (prefetch_busy_o);
    // Idle means every response has come back
    check_value("backpressure_kill", "requests in flight when idle", '0, word_t'(in_flight));
    check_value("backpressure_kill", "valid when idle", word_t'(1), word_t'(instr_valid_o));
    check_value("backpressure_kill", "address when idle", pc, instr_addr_o);
    @(posedge clk);
    kill_i        <= 1'b1;
    prefetch_en_i <= 1'b0;
    @(posedge clk);
    kill_i <= 1'b0;
    repeat (12) begin
      @(posedge clk);
      check_value("backpressure_kill", "valid after kill", '0, word_t'(instr_valid_o));
    end
    pc = 32'h10;
    branch_to(pc);
    collect("backpressure_kill", pc, 8, 30);
  endtask

  initial begin
    void'($urandom(32'hccd0));
    rst_n         <= 1'b0;
    kill_i        <= 1'b0;
    branch_i      <= 1'b0;
    branch_addr_i <= '0;
    prefetch_en_i <= 1'b0;
    fetch_ready_i <= 1'b1;
    instr_ready_i <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    aligned_stream();
    mixed_stream();
    unaligned_branch();
    branch_flush();
    error_merge();
    backpressure_kill();
    if (u_align_buffer.u_chk.fail_cnt != 0) begin
      $display("** FAIL **");
      $fatal(1, "%0d assertion failures", u_align_buffer.u_chk.fail_cnt);
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule
